// File: src/dual_issue_defines.svh
`ifndef DUAL_ISSUE_DEFINES_SVH
`define DUAL_ISSUE_DEFINES_SVH

// operand and result width
`define DATA_W 32
// architectural registers
`define REG_COUNT 32
`define REG_ADDR_W 5

`endif

// File: src/dual_issue_pkg.sv
`include "dual_issue_defines.svh"

package dual_issue_pkg;

typedef logic [`DATA_W-1:0] word_t;
typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

// shifts use the low five bits of src2
typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_NOR   = 4'd5,
    ALU_SLL   = 4'd6,
    ALU_SRL   = 4'd7,
    ALU_SRA   = 4'd8,
    ALU_SLT   = 4'd9,
    ALU_SLTU  = 4'd10,
    ALU_LU12I = 4'd11
} alu_op_t;

endpackage

// File: src/regfile.sv
`include "dual_issue_defines.svh"

module regfile (
    input  logic                      clk,
    input  dual_issue_pkg::reg_addr_t i_raddr1,
    output dual_issue_pkg::word_t     o_rdata1,
    input  dual_issue_pkg::reg_addr_t i_raddr2,
    output dual_issue_pkg::word_t     o_rdata2,
    input  dual_issue_pkg::reg_addr_t i_raddr3,
    output dual_issue_pkg::word_t     o_rdata3,
    input  dual_issue_pkg::reg_addr_t i_raddr4,
    output dual_issue_pkg::word_t     o_rdata4,
    input  logic                      i_we1,
    input  dual_issue_pkg::reg_addr_t i_waddr1,
    input  dual_issue_pkg::word_t     i_wdata1,
    input  logic                      i_we2,
    input  dual_issue_pkg::reg_addr_t i_waddr2,
    input  dual_issue_pkg::word_t     i_wdata2
);

dual_issue_pkg::word_t regs [`REG_COUNT];

always_ff @(posedge clk) begin
    if (i_we1)
        regs[i_waddr1] <= i_wdata1;
    // port 2 carries the younger lane and lands last on a shared address
    if (i_we2)
        regs[i_waddr2] <= i_wdata2;
end

// register zero is hardwired
assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];
assign o_rdata3 = (i_raddr3 == '0) ? '0 : regs[i_raddr3];
assign o_rdata4 = (i_raddr4 == '0) ? '0 : regs[i_raddr4];

endmodule

// File: src/operand_read.sv
module operand_read (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_a_valid,
    input  dual_issue_pkg::word_t     i_a_pc,
    input  dual_issue_pkg::alu_op_t   i_a_op,
    input  dual_issue_pkg::reg_addr_t i_a_src1,
    input  dual_issue_pkg::reg_addr_t i_a_src2,
    input  logic                      i_a_src2_is_imm,
    input  dual_issue_pkg::word_t     i_a_imm,
    input  dual_issue_pkg::reg_addr_t i_a_dest,
    input  logic                      i_b_valid,
    input  dual_issue_pkg::word_t     i_b_pc,
    input  dual_issue_pkg::alu_op_t   i_b_op,
    input  dual_issue_pkg::reg_addr_t i_b_src1,
    input  dual_issue_pkg::reg_addr_t i_b_src2,
    input  logic                      i_b_src2_is_imm,
    input  dual_issue_pkg::word_t     i_b_imm,
    input  dual_issue_pkg::reg_addr_t i_b_dest,
    output logic [1:0]                o_consume,
    output dual_issue_pkg::reg_addr_t o_raddr1,
    output dual_issue_pkg::reg_addr_t o_raddr2,
    output dual_issue_pkg::reg_addr_t o_raddr3,
    output dual_issue_pkg::reg_addr_t o_raddr4,
    input  dual_issue_pkg::word_t     i_rdata1,
    input  dual_issue_pkg::word_t     i_rdata2,
    input  dual_issue_pkg::word_t     i_rdata3,
    input  dual_issue_pkg::word_t     i_rdata4,
    input  logic                      i_ex_a_valid,
    input  dual_issue_pkg::reg_addr_t i_ex_a_dest,
    input  dual_issue_pkg::word_t     i_ex_a_result,
    input  logic                      i_ex_b_valid,
    input  dual_issue_pkg::reg_addr_t i_ex_b_dest,
    input  dual_issue_pkg::word_t     i_ex_b_result,
    input  logic                      i_wb_a_valid,
    input  dual_issue_pkg::reg_addr_t i_wb_a_dest,
    input  dual_issue_pkg::word_t     i_wb_a_data,
    input  logic                      i_wb_b_valid,
    input  dual_issue_pkg::reg_addr_t i_wb_b_dest,
    input  dual_issue_pkg::word_t     i_wb_b_data,
    output logic                      o_ro_a_valid,
    output dual_issue_pkg::word_t     o_ro_a_pc,
    output dual_issue_pkg::alu_op_t   o_ro_a_op,
    output dual_issue_pkg::word_t     o_ro_a_src1,
    output dual_issue_pkg::word_t     o_ro_a_src2,
    output dual_issue_pkg::reg_addr_t o_ro_a_dest,
    output logic                      o_ro_b_valid,
    output dual_issue_pkg::word_t     o_ro_b_pc,
    output dual_issue_pkg::alu_op_t   o_ro_b_op,
    output dual_issue_pkg::word_t     o_ro_b_src1,
    output dual_issue_pkg::word_t     o_ro_b_src2,
    output dual_issue_pkg::reg_addr_t o_ro_b_dest
);

logic                      b_reads_a;
logic                      id_a_valid, id_b_valid;
dual_issue_pkg::word_t     id_a_pc, id_b_pc;
dual_issue_pkg::alu_op_t   id_a_op, id_b_op;
dual_issue_pkg::reg_addr_t id_a_src1, id_b_src1;
dual_issue_pkg::reg_addr_t id_a_src2, id_b_src2;
logic                      id_a_src2_is_imm, id_b_src2_is_imm;
dual_issue_pkg::word_t     id_a_imm, id_b_imm;
dual_issue_pkg::reg_addr_t id_a_dest, id_b_dest;
dual_issue_pkg::word_t     a_src1, a_src2, b_src1, b_src2;

// lane b cannot read what lane a of the same pair is about to write
assign b_reads_a = (i_a_dest != '0) &&
    (i_b_src1 == i_a_dest || (!i_b_src2_is_imm && i_b_src2 == i_a_dest));

always_comb begin
    if (!i_a_valid)
        o_consume = 2'd0;
    else if (!i_b_valid || b_reads_a)
        o_consume = 2'd1;
    else
        o_consume = 2'd2;
end

always_ff @(posedge clk) begin
    if (reset) begin
        id_a_valid <= 1'b0;
        id_b_valid <= 1'b0;
    end else begin
        id_a_valid <= o_consume != 2'd0;
        id_b_valid <= o_consume == 2'd2;
    end
end

always_ff @(posedge clk) begin
    id_a_pc          <= i_a_pc;
    id_a_op          <= i_a_op;
    id_a_src1        <= i_a_src1;
    id_a_src2        <= i_a_src2;
    id_a_src2_is_imm <= i_a_src2_is_imm;
    id_a_imm         <= i_a_imm;
    id_a_dest        <= i_a_dest;
    id_b_pc          <= i_b_pc;
    id_b_op          <= i_b_op;
    id_b_src1        <= i_b_src1;
    id_b_src2        <= i_b_src2;
    id_b_src2_is_imm <= i_b_src2_is_imm;
    id_b_imm         <= i_b_imm;
    id_b_dest        <= i_b_dest;
end

assign o_raddr1 = id_a_src1;
assign o_raddr2 = id_a_src2;
assign o_raddr3 = id_b_src1;
assign o_raddr4 = id_b_src2;

// youngest producer wins and the register file covers anything older
function automatic dual_issue_pkg::word_t forward(
    input dual_issue_pkg::reg_addr_t addr,
    input dual_issue_pkg::word_t     rf_data
);
    if (addr == '0)
        return '0;
    if (i_ex_b_valid && i_ex_b_dest == addr)
        return i_ex_b_result;
    if (i_ex_a_valid && i_ex_a_dest == addr)
        return i_ex_a_result;
    if (i_wb_b_valid && i_wb_b_dest == addr)
        return i_wb_b_data;
    if (i_wb_a_valid && i_wb_a_dest == addr)
        return i_wb_a_data;
    return rf_data;
endfunction

always_comb begin
    a_src1 = forward(id_a_src1, i_rdata1);
    a_src2 = id_a_src2_is_imm ? id_a_imm : forward(id_a_src2, i_rdata2);
    b_src1 = forward(id_b_src1, i_rdata3);
    b_src2 = id_b_src2_is_imm ? id_b_imm : forward(id_b_src2, i_rdata4);
end

always_ff @(posedge clk) begin
    if (reset) begin
        o_ro_a_valid <= 1'b0;
        o_ro_b_valid <= 1'b0;
    end else begin
        o_ro_a_valid <= id_a_valid;
        o_ro_b_valid <= id_b_valid;
    end
end

always_ff @(posedge clk) begin
    o_ro_a_pc   <= id_a_pc;
    o_ro_a_op   <= id_a_op;
    o_ro_a_src1 <= a_src1;
    o_ro_a_src2 <= a_src2;
    o_ro_a_dest <= id_a_dest;
    o_ro_b_pc   <= id_b_pc;
    o_ro_b_op   <= id_b_op;
    o_ro_b_src1 <= b_src1;
    o_ro_b_src2 <= b_src2;
    o_ro_b_dest <= id_b_dest;
end

a_consume_bound: assert property (@(posedge clk) disable iff (reset)
    o_consume <= {1'b0, i_a_valid} + {1'b0, i_b_valid})
    else $error("consume %0d exceeds valid inputs", o_consume);

a_b_needs_a: assert property (@(posedge clk) disable iff (reset)
    i_b_valid |-> i_a_valid)
    else $error("lane b presented without lane a");

endmodule

// File: src/alu.sv
module alu (
    input  dual_issue_pkg::alu_op_t i_op,
    input  dual_issue_pkg::word_t   i_src1,
    input  dual_issue_pkg::word_t   i_src2,
    output dual_issue_pkg::word_t   o_result
);

logic [4:0] shamt;

assign shamt = i_src2[4:0];

always_comb begin
    case (i_op)
        dual_issue_pkg::ALU_ADD:
            o_result = i_src1 + i_src2;
        dual_issue_pkg::ALU_SUB:
            o_result = i_src1 - i_src2;
        dual_issue_pkg::ALU_AND:
            o_result = i_src1 & i_src2;
        dual_issue_pkg::ALU_OR:
            o_result = i_src1 | i_src2;
        dual_issue_pkg::ALU_XOR:
            o_result = i_src1 ^ i_src2;
        dual_issue_pkg::ALU_NOR:
            o_result = ~(i_src1 | i_src2);
        dual_issue_pkg::ALU_SLL:
            o_result = i_src1 << shamt;
        dual_issue_pkg::ALU_SRL:
            o_result = i_src1 >> shamt;
        dual_issue_pkg::ALU_SRA:
            o_result = $signed(i_src1) >>> shamt;
        // compare results are zero extended to a full word
        dual_issue_pkg::ALU_SLT:
            o_result = dual_issue_pkg::word_t'($signed(i_src1) < $signed(i_src2));
        dual_issue_pkg::ALU_SLTU:
            o_result = dual_issue_pkg::word_t'(i_src1 < i_src2);
        dual_issue_pkg::ALU_LU12I:
            o_result = i_src2 << 12;
        default:
            o_result = '0;
    endcase
end

endmodule

// File: src/execute_stage.sv
module execute_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_ro_a_valid,
    input  dual_issue_pkg::word_t     i_ro_a_pc,
    input  dual_issue_pkg::alu_op_t   i_ro_a_op,
    input  dual_issue_pkg::word_t     i_ro_a_src1,
    input  dual_issue_pkg::word_t     i_ro_a_src2,
    input  dual_issue_pkg::reg_addr_t i_ro_a_dest,
    input  logic                      i_ro_b_valid,
    input  dual_issue_pkg::word_t     i_ro_b_pc,
    input  dual_issue_pkg::alu_op_t   i_ro_b_op,
    input  dual_issue_pkg::word_t     i_ro_b_src1,
    input  dual_issue_pkg::word_t     i_ro_b_src2,
    input  dual_issue_pkg::reg_addr_t i_ro_b_dest,
    output logic                      o_ex_a_valid,
    output dual_issue_pkg::reg_addr_t o_ex_a_dest,
    output dual_issue_pkg::word_t     o_ex_a_result,
    output logic                      o_ex_b_valid,
    output dual_issue_pkg::reg_addr_t o_ex_b_dest,
    output dual_issue_pkg::word_t     o_ex_b_result,
    output logic                      o_wb_a_valid,
    output dual_issue_pkg::reg_addr_t o_wb_a_dest,
    output dual_issue_pkg::word_t     o_wb_a_data,
    output logic                      o_wb_b_valid,
    output dual_issue_pkg::reg_addr_t o_wb_b_dest,
    output dual_issue_pkg::word_t     o_wb_b_data,
    output logic                      o_we1,
    output dual_issue_pkg::reg_addr_t o_waddr1,
    output dual_issue_pkg::word_t     o_wdata1,
    output logic                      o_we2,
    output dual_issue_pkg::reg_addr_t o_waddr2,
    output dual_issue_pkg::word_t     o_wdata2,
    output dual_issue_pkg::word_t     o_wb_a_pc,
    output logic                      o_wb_a_wen,
    output dual_issue_pkg::reg_addr_t o_wb_a_wnum,
    output dual_issue_pkg::word_t     o_wb_a_wdata,
    output dual_issue_pkg::word_t     o_wb_b_pc,
    output logic                      o_wb_b_wen,
    output dual_issue_pkg::reg_addr_t o_wb_b_wnum,
    output dual_issue_pkg::word_t     o_wb_b_wdata
);

alu alu_a_i (
    .i_op(i_ro_a_op),
    .i_src1(i_ro_a_src1),
    .i_src2(i_ro_a_src2),
    .o_result(o_ex_a_result)
);

alu alu_b_i (
    .i_op(i_ro_b_op),
    .i_src1(i_ro_b_src1),
    .i_src2(i_ro_b_src2),
    .o_result(o_ex_b_result)
);

// results are visible to operand read in the same cycle
assign o_ex_a_valid = i_ro_a_valid;
assign o_ex_a_dest  = i_ro_a_dest;
assign o_ex_b_valid = i_ro_b_valid;
assign o_ex_b_dest  = i_ro_b_dest;

always_ff @(posedge clk) begin
    if (reset) begin
        o_wb_a_valid <= 1'b0;
        o_wb_b_valid <= 1'b0;
    end else begin
        o_wb_a_valid <= i_ro_a_valid;
        o_wb_b_valid <= i_ro_b_valid;
    end
end

always_ff @(posedge clk) begin
    o_wb_a_pc   <= i_ro_a_pc;
    o_wb_a_dest <= i_ro_a_dest;
    o_wb_a_data <= o_ex_a_result;
    o_wb_b_pc   <= i_ro_b_pc;
    o_wb_b_dest <= i_ro_b_dest;
    o_wb_b_data <= o_ex_b_result;
end

// writes to r0 are dropped
assign o_we1    = o_wb_a_valid && o_wb_a_dest != '0;
assign o_waddr1 = o_wb_a_dest;
assign o_wdata1 = o_wb_a_data;
assign o_we2    = o_wb_b_valid && o_wb_b_dest != '0;
assign o_waddr2 = o_wb_b_dest;
assign o_wdata2 = o_wb_b_data;

assign o_wb_a_wen   = o_we1;
assign o_wb_a_wnum  = o_wb_a_dest;
assign o_wb_a_wdata = o_wb_a_data;
assign o_wb_b_wen   = o_we2;
assign o_wb_b_wnum  = o_wb_b_dest;
assign o_wb_b_wdata = o_wb_b_data;

a_wen_a: assert property (@(posedge clk) disable iff (reset)
    o_wb_a_wen |-> o_wb_a_wnum != '0 && $past(i_ro_a_valid))
    else $error("lane a write enable without a live nonzero dest");

a_wen_b: assert property (@(posedge clk) disable iff (reset)
    o_wb_b_wen |-> o_wb_b_wnum != '0 && $past(i_ro_b_valid))
    else $error("lane b write enable without a live nonzero dest");

endmodule

// File: src/dual_issue_core.sv
module dual_issue_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_a_valid,
    input  dual_issue_pkg::word_t     i_a_pc,
    input  dual_issue_pkg::alu_op_t   i_a_op,
    input  dual_issue_pkg::reg_addr_t i_a_src1,
    input  dual_issue_pkg::reg_addr_t i_a_src2,
    input  logic                      i_a_src2_is_imm,
    input  dual_issue_pkg::word_t     i_a_imm,
    input  dual_issue_pkg::reg_addr_t i_a_dest,
    input  logic                      i_b_valid,
    input  dual_issue_pkg::word_t     i_b_pc,
    input  dual_issue_pkg::alu_op_t   i_b_op,
    input  dual_issue_pkg::reg_addr_t i_b_src1,
    input  dual_issue_pkg::reg_addr_t i_b_src2,
    input  logic                      i_b_src2_is_imm,
    input  dual_issue_pkg::word_t     i_b_imm,
    input  dual_issue_pkg::reg_addr_t i_b_dest,
    output logic [1:0]                o_consume,
    output dual_issue_pkg::word_t     o_wb_a_pc,
    output logic                      o_wb_a_wen,
    output dual_issue_pkg::reg_addr_t o_wb_a_wnum,
    output dual_issue_pkg::word_t     o_wb_a_wdata,
    output dual_issue_pkg::word_t     o_wb_b_pc,
    output logic                      o_wb_b_wen,
    output dual_issue_pkg::reg_addr_t o_wb_b_wnum,
    output dual_issue_pkg::word_t     o_wb_b_wdata
);

dual_issue_pkg::reg_addr_t rf_raddr1, rf_raddr2, rf_raddr3, rf_raddr4;
dual_issue_pkg::word_t     rf_rdata1, rf_rdata2, rf_rdata3, rf_rdata4;
logic                      rf_we1, rf_we2;
dual_issue_pkg::reg_addr_t rf_waddr1, rf_waddr2;
dual_issue_pkg::word_t     rf_wdata1, rf_wdata2;

logic                      ro_a_valid, ro_b_valid;
dual_issue_pkg::word_t     ro_a_pc, ro_b_pc;
dual_issue_pkg::alu_op_t   ro_a_op, ro_b_op;
dual_issue_pkg::word_t     ro_a_src1, ro_b_src1;
dual_issue_pkg::word_t     ro_a_src2, ro_b_src2;
dual_issue_pkg::reg_addr_t ro_a_dest, ro_b_dest;

logic                      ex_a_valid, ex_b_valid;
dual_issue_pkg::reg_addr_t ex_a_dest, ex_b_dest;
dual_issue_pkg::word_t     ex_a_result, ex_b_result;
logic                      wb_a_valid, wb_b_valid;
dual_issue_pkg::reg_addr_t wb_a_dest, wb_b_dest;
dual_issue_pkg::word_t     wb_a_data, wb_b_data;

operand_read operand_read_i (
    .clk(clk),
    .reset(reset),
    .i_a_valid(i_a_valid),
    .i_a_pc(i_a_pc),
    .i_a_op(i_a_op),
    .i_a_src1(i_a_src1),
    .i_a_src2(i_a_src2),
    .i_a_src2_is_imm(i_a_src2_is_imm),
    .i_a_imm(i_a_imm),
    .i_a_dest(i_a_dest),
    .i_b_valid(i_b_valid),
    .i_b_pc(i_b_pc),
    .i_b_op(i_b_op),
    .i_b_src1(i_b_src1),
    .i_b_src2(i_b_src2),
    .i_b_src2_is_imm(i_b_src2_is_imm),
    .i_b_imm(i_b_imm),
    .i_b_dest(i_b_dest),
    .o_consume(o_consume),
    .o_raddr1(rf_raddr1),
    .o_raddr2(rf_raddr2),
    .o_raddr3(rf_raddr3),
    .o_raddr4(rf_raddr4),
    .i_rdata1(rf_rdata1),
    .i_rdata2(rf_rdata2),
    .i_rdata3(rf_rdata3),
    .i_rdata4(rf_rdata4),
    .i_ex_a_valid(ex_a_valid),
    .i_ex_a_dest(ex_a_dest),
    .i_ex_a_result(ex_a_result),
    .i_ex_b_valid(ex_b_valid),
    .i_ex_b_dest(ex_b_dest),
    .i_ex_b_result(ex_b_result),
    .i_wb_a_valid(wb_a_valid),
    .i_wb_a_dest(wb_a_dest),
    .i_wb_a_data(wb_a_data),
    .i_wb_b_valid(wb_b_valid),
    .i_wb_b_dest(wb_b_dest),
    .i_wb_b_data(wb_b_data),
    .o_ro_a_valid(ro_a_valid),
    .o_ro_a_pc(ro_a_pc),
    .o_ro_a_op(ro_a_op),
    .o_ro_a_src1(ro_a_src1),
    .o_ro_a_src2(ro_a_src2),
    .o_ro_a_dest(ro_a_dest),
    .o_ro_b_valid(ro_b_valid),
    .o_ro_b_pc(ro_b_pc),
    .o_ro_b_op(ro_b_op),
    .o_ro_b_src1(ro_b_src1),
    .o_ro_b_src2(ro_b_src2),
    .o_ro_b_dest(ro_b_dest)
);

execute_stage execute_stage_i (
    .clk(clk),
    .reset(reset),
    .i_ro_a_valid(ro_a_valid),
    .i_ro_a_pc(ro_a_pc),
    .i_ro_a_op(ro_a_op),
    .i_ro_a_src1(ro_a_src1),
    .i_ro_a_src2(ro_a_src2),
    .i_ro_a_dest(ro_a_dest),
    .i_ro_b_valid(ro_b_valid),
    .i_ro_b_pc(ro_b_pc),
    .i_ro_b_op(ro_b_op),
    .i_ro_b_src1(ro_b_src1),
    .i_ro_b_src2(ro_b_src2),
    .i_ro_b_dest(ro_b_dest),
    .o_ex_a_valid(ex_a_valid),
    .o_ex_a_dest(ex_a_dest),
    .o_ex_a_result(ex_a_result),
    .o_ex_b_valid(ex_b_valid),
    .o_ex_b_dest(ex_b_dest),
    .o_ex_b_result(ex_b_result),
    .o_wb_a_valid(wb_a_valid),
    .o_wb_a_dest(wb_a_dest),
    .o_wb_a_data(wb_a_data),
    .o_wb_b_valid(wb_b_valid),
    .o_wb_b_dest(wb_b_dest),
    .o_wb_b_data(wb_b_data),
    .o_we1(rf_we1),
    .o_waddr1(rf_waddr1),
    .o_wdata1(rf_wdata1),
    .o_we2(rf_we2),
    .o_waddr2(rf_waddr2),
    .o_wdata2(rf_wdata2),
    .o_wb_a_pc(o_wb_a_pc),
    .o_wb_a_wen(o_wb_a_wen),
    .o_wb_a_wnum(o_wb_a_wnum),
    .o_wb_a_wdata(o_wb_a_wdata),
    .o_wb_b_pc(o_wb_b_pc),
    .o_wb_b_wen(o_wb_b_wen),
    .o_wb_b_wnum(o_wb_b_wnum),
    .o_wb_b_wdata(o_wb_b_wdata)
);

regfile regfile_i (
    .clk(clk),
    .i_raddr1(rf_raddr1),
    .o_rdata1(rf_rdata1),
    .i_raddr2(rf_raddr2),
    .o_rdata2(rf_rdata2),
    .i_raddr3(rf_raddr3),
    .o_rdata3(rf_rdata3),
    .i_raddr4(rf_raddr4),
    .o_rdata4(rf_rdata4),
    .i_we1(rf_we1),
    .i_waddr1(rf_waddr1),
    .i_wdata1(rf_wdata1),
    .i_we2(rf_we2),
    .i_waddr2(rf_waddr2),
    .i_wdata2(rf_wdata2)
);

endmodule

// File: bench/tb_dual_issue_core.sv
`include "dual_issue_defines.svh"

module tb_dual_issue_core;

typedef struct packed {
    dual_issue_pkg::word_t     pc;
    dual_issue_pkg::alu_op_t   op;
    dual_issue_pkg::reg_addr_t src1;
    dual_issue_pkg::reg_addr_t src2;
    logic                      src2_is_imm;
    dual_issue_pkg::word_t     imm;
    dual_issue_pkg::reg_addr_t dest;
} op_t;

// expected debug port contents tagged with the edge that took the op
typedef struct packed {
    logic [31:0]               take_edge;
    dual_issue_pkg::word_t     pc;
    logic                      wen;
    dual_issue_pkg::reg_addr_t wnum;
    dual_issue_pkg::word_t     wdata;
} wb_t;

logic clk;
logic reset;
logic a_valid;
logic b_valid;
op_t  drv_a;
op_t  drv_b;

logic [1:0]                consume;
dual_issue_pkg::word_t     wb_a_pc, wb_b_pc;
logic                      wb_a_wen, wb_b_wen;
dual_issue_pkg::reg_addr_t wb_a_wnum, wb_b_wnum;
dual_issue_pkg::word_t     wb_a_wdata, wb_b_wdata;

integer                seed;
int                    edge_count = 0;
op_t                   prog[$];
wb_t                   exp_a_q[$];
wb_t                   exp_b_q[$];
wb_t                   exp_a, exp_b;
logic                  exp_a_valid, exp_b_valid;
logic [1:0]            exp_consume;
dual_issue_pkg::word_t model_regs [`REG_COUNT];
dual_issue_pkg::word_t next_pc;
int                    consume_errors;
int                    lane_a_errors;
int                    lane_b_errors;
int                    run_errors;

dual_issue_core dual_issue_core_i (
    .clk(clk),
    .reset(reset),
    .i_a_valid(a_valid),
    .i_a_pc(drv_a.pc),
    .i_a_op(drv_a.op),
    .i_a_src1(drv_a.src1),
    .i_a_src2(drv_a.src2),
    .i_a_src2_is_imm(drv_a.src2_is_imm),
    .i_a_imm(drv_a.imm),
    .i_a_dest(drv_a.dest),
    .i_b_valid(b_valid),
    .i_b_pc(drv_b.pc),
    .i_b_op(drv_b.op),
    .i_b_src1(drv_b.src1),
    .i_b_src2(drv_b.src2),
    .i_b_src2_is_imm(drv_b.src2_is_imm),
    .i_b_imm(drv_b.imm),
    .i_b_dest(drv_b.dest),
    .o_consume(consume),
    .o_wb_a_pc(wb_a_pc),
    .o_wb_a_wen(wb_a_wen),
    .o_wb_a_wnum(wb_a_wnum),
    .o_wb_a_wdata(wb_a_wdata),
    .o_wb_b_pc(wb_b_pc),
    .o_wb_b_wen(wb_b_wen),
    .o_wb_b_wnum(wb_b_wnum),
    .o_wb_b_wdata(wb_b_wdata)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

always @(posedge clk) edge_count <= edge_count + 1;

// b waits when it reads a's nonzero dest
function automatic logic [1:0] consume_count(
    input logic av,
    input logic bv,
    input op_t  a,
    input op_t  b
);
    logic conflict;
    conflict = (a.dest != '0) &&
        (b.src1 == a.dest || (!b.src2_is_imm && b.src2 == a.dest));
    if (!av)
        return 2'd0;
    if (!bv || conflict)
        return 2'd1;
    return 2'd2;
endfunction

function automatic dual_issue_pkg::word_t expected_result(
    input dual_issue_pkg::alu_op_t op,
    input dual_issue_pkg::word_t   s1,
    input dual_issue_pkg::word_t   s2
);
    case (op)
        dual_issue_pkg::ALU_ADD:   return s1 + s2;
        dual_issue_pkg::ALU_SUB:   return s1 - s2;
        dual_issue_pkg::ALU_AND:   return s1 & s2;
        dual_issue_pkg::ALU_OR:    return s1 | s2;
        dual_issue_pkg::ALU_XOR:   return s1 ^ s2;
        dual_issue_pkg::ALU_NOR:   return ~(s1 | s2);
        dual_issue_pkg::ALU_SLL:   return s1 << s2[4:0];
        dual_issue_pkg::ALU_SRL:   return s1 >> s2[4:0];
        dual_issue_pkg::ALU_SRA:   return $signed(s1) >>> s2[4:0];
        dual_issue_pkg::ALU_SLT:   return {31'd0, $signed(s1) < $signed(s2)};
        dual_issue_pkg::ALU_SLTU:  return {31'd0, s1 < s2};
        dual_issue_pkg::ALU_LU12I: return s2 << 12;
        default:                   return '0;
    endcase
endfunction

always_comb exp_consume = consume_count(a_valid, b_valid, drv_a, drv_b);

task automatic push_op(
    input dual_issue_pkg::alu_op_t   op,
    input dual_issue_pkg::reg_addr_t dest,
    input dual_issue_pkg::reg_addr_t src1,
    input dual_issue_pkg::reg_addr_t src2,
    input logic                      src2_is_imm,
    input dual_issue_pkg::word_t     imm
);
    op_t o;
    o.pc = next_pc;
    o.op = op;
    o.dest = dest;
    o.src1 = src1;
    o.src2 = src2;
    o.src2_is_imm = src2_is_imm;
    o.imm = imm;
    prog.push_back(o);
    next_pc = next_pc + 32'd4;
endtask

// drawing from registers 0 to 7 makes dependencies and shared dests common
task automatic push_random_op();
    logic [31:0] r;
    logic [31:0] imm;
    r = $random(seed);
    imm = $random(seed);
    push_op(dual_issue_pkg::alu_op_t'(r[3:0] % 4'd12), {2'b00, r[6:4]},
        {2'b00, r[9:7]}, {2'b00, r[12:10]}, r[13], imm);
endtask

// model executes in program order at the take
task automatic take_op(input op_t op, input logic lane_b);
    wb_t                   e;
    dual_issue_pkg::word_t s1;
    dual_issue_pkg::word_t s2;
    s1 = model_regs[op.src1];
    s2 = op.src2_is_imm ? op.imm : model_regs[op.src2];
    e.take_edge = edge_count + 1;
    e.pc = op.pc;
    e.wen = op.dest != '0;
    e.wnum = op.dest;
    e.wdata = expected_result(op.op, s1, s2);
    if (e.wen)
        model_regs[op.dest] = e.wdata;
    if (lane_b)
        exp_b_q.push_back(e);
    else
        exp_a_q.push_back(e);
endtask

task automatic drive_pair(input logic idle, input logic a_only);
    logic [1:0] n;
    a_valid = 1'b0;
    b_valid = 1'b0;
    if (!idle && prog.size() > 0) begin
        drv_a = prog[0];
        a_valid = 1'b1;
        if (!a_only && prog.size() > 1) begin
            drv_b = prog[1];
            b_valid = 1'b1;
        end
    end
    n = consume_count(a_valid, b_valid, drv_a, drv_b);
    if (n != 2'd0) begin
        take_op(drv_a, 1'b0);
        void'(prog.pop_front());
    end
    if (n == 2'd2) begin
        take_op(drv_b, 1'b1);
        void'(prog.pop_front());
    end
endtask

// an op taken at edge N is expected on the debug ports after edge N+2
task automatic update_expected();
    exp_a_valid = 1'b0;
    exp_b_valid = 1'b0;
    exp_a = '0;
    exp_b = '0;
    if (exp_a_q.size() > 0 && exp_a_q[0].take_edge + 2 == edge_count) begin
        exp_a = exp_a_q.pop_front();
        exp_a_valid = 1'b1;
    end
    if (exp_b_q.size() > 0 && exp_b_q[0].take_edge + 2 == edge_count) begin
        exp_b = exp_b_q.pop_front();
        exp_b_valid = 1'b1;
    end
endtask

task automatic next_cycle(input logic idle, input logic a_only);
    @(negedge clk);
    update_expected();
    drive_pair(idle, a_only);
endtask

task automatic run_program(input logic gaps);
    int          cycles;
    logic [31:0] r;
    cycles = 0;
    while (prog.size() > 0 && cycles < 4000) begin
        r = $random(seed);
        next_cycle(gaps && r[2:0] == 3'd0, gaps && r[5:3] == 3'd0);
        cycles++;
    end
    if (prog.size() > 0) begin
        run_errors++;
        $display("timeout: %0d ops were never consumed", prog.size());
        prog.delete();
    end
endtask

task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    while ((exp_a_q.size() > 0 || exp_b_q.size() > 0) && cycles < 20) begin
        next_cycle(1'b1, 1'b0);
        cycles++;
    end
    if (exp_a_q.size() > 0 || exp_b_q.size() > 0) begin
        run_errors++;
        $display("timeout: expected writebacks never became due");
    end
    // last expected values meet their check before one more idle edge
    next_cycle(1'b1, 1'b0);
    next_cycle(1'b1, 1'b0);
endtask

consume_check: assert property (@(posedge clk) disable iff (reset) consume == exp_consume)
else begin
    consume_errors++;
    $display("CHECK FAILED time=%0t o_consume got %0d expected %0d",
        $time, $sampled(consume), $sampled(exp_consume));
end

wen_a_check: assert property (@(posedge clk) disable iff (reset) wb_a_wen == exp_a.wen)
else begin
    lane_a_errors++;
    $display("CHECK FAILED time=%0t o_wb_a_wen got %0b expected %0b",
        $time, $sampled(wb_a_wen), $sampled(exp_a.wen));
end

pc_a_check: assert property (@(posedge clk) disable iff (reset)
    exp_a_valid |-> wb_a_pc == exp_a.pc)
else begin
    lane_a_errors++;
    $display("CHECK FAILED time=%0t o_wb_a_pc got %h expected %h",
        $time, $sampled(wb_a_pc), $sampled(exp_a.pc));
end

wnum_a_check: assert property (@(posedge clk) disable iff (reset)
    exp_a_valid |-> wb_a_wnum == exp_a.wnum)
else begin
    lane_a_errors++;
    $display("CHECK FAILED time=%0t o_wb_a_wnum got %0d expected %0d",
        $time, $sampled(wb_a_wnum), $sampled(exp_a.wnum));
end

wdata_a_check: assert property (@(posedge clk) disable iff (reset)
    exp_a_valid |-> wb_a_wdata == exp_a.wdata)
else begin
    lane_a_errors++;
    $display("CHECK FAILED time=%0t o_wb_a_wdata got %h expected %h",
        $time, $sampled(wb_a_wdata), $sampled(exp_a.wdata));
end

wen_b_check: assert property (@(posedge clk) disable iff (reset) wb_b_wen == exp_b.wen)
else begin
    lane_b_errors++;
    $display("CHECK FAILED time=%0t o_wb_b_wen got %0b expected %0b",
        $time, $sampled(wb_b_wen), $sampled(exp_b.wen));
end

pc_b_check: assert property (@(posedge clk) disable iff (reset)
    exp_b_valid |-> wb_b_pc == exp_b.pc)
else begin
    lane_b_errors++;
    $display("CHECK FAILED time=%0t o_wb_b_pc got %h expected %h",
        $time, $sampled(wb_b_pc), $sampled(exp_b.pc));
end

wnum_b_check: assert property (@(posedge clk) disable iff (reset)
    exp_b_valid |-> wb_b_wnum == exp_b.wnum)
else begin
    lane_b_errors++;
    $display("CHECK FAILED time=%0t o_wb_b_wnum got %0d expected %0d",
        $time, $sampled(wb_b_wnum), $sampled(exp_b.wnum));
end

wdata_b_check: assert property (@(posedge clk) disable iff (reset)
    exp_b_valid |-> wb_b_wdata == exp_b.wdata)
else begin
    lane_b_errors++;
    $display("CHECK FAILED time=%0t o_wb_b_wdata got %h expected %h",
        $time, $sampled(wb_b_wdata), $sampled(exp_b.wdata));
end

initial begin
    int          i;
    logic [31:0] r;
    reset = 1'b1;
    a_valid = 1'b0;
    b_valid = 1'b0;
    drv_a = '0;
    drv_b = '0;
    exp_a = '0;
    exp_b = '0;
    exp_a_valid = 1'b0;
    exp_b_valid = 1'b0;
    seed = 32'h32af_f7dc;
    next_pc = 32'h0000_1000;
    consume_errors = 0;
    lane_a_errors = 0;
    lane_b_errors = 0;
    run_errors = 0;
    for (i = 0; i < `REG_COUNT; i++)
        model_regs[i] = '0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (i = 0; i < 4; i++)
        next_cycle(1'b1, 1'b0);

    // eight paired loads with the first one to r0
    for (i = 0; i < 8; i++) begin
        r = $random(seed);
        push_op(dual_issue_pkg::ALU_ADD, i[4:0], 5'd0, 5'd0, 1'b1, r);
    end
    // both lanes write r3 and the next op reads it
    push_op(dual_issue_pkg::ALU_ADD, 5'd3, 5'd1, 5'd0, 1'b1, 32'd5);
    push_op(dual_issue_pkg::ALU_SUB, 5'd3, 5'd2, 5'd1, 1'b0, 32'd0);
    push_op(dual_issue_pkg::ALU_XOR, 5'd4, 5'd3, 5'd2, 1'b0, 32'd0);
    push_op(dual_issue_pkg::ALU_OR, 5'd0, 5'd1, 5'd2, 1'b0, 32'd0);
    push_op(dual_issue_pkg::ALU_NOR, 5'd5, 5'd0, 5'd0, 1'b0, 32'd0);
    push_op(dual_issue_pkg::ALU_SLL, 5'd6, 5'd4, 5'd0, 1'b1, 32'd7);
    push_op(dual_issue_pkg::ALU_SRA, 5'd7, 5'd6, 5'd2, 1'b0, 32'd0);
    run_program(1'b0);

    for (i = 0; i < 400; i++)
        push_random_op();
    run_program(1'b1);
    drain_pipeline();

    $display("errors: consume=%0d lane_a=%0d lane_b=%0d run=%0d",
        consume_errors, lane_a_errors, lane_b_errors, run_errors);
    if (consume_errors + lane_a_errors + lane_b_errors + run_errors == 0)
        $display("Verification passed");
    else
        $display("Verification failed");
    $finish;
end

endmodule

// File: files.f
+incdir+src
src/dual_issue_pkg.sv
src/regfile.sv
src/operand_read.sv
src/alu.sv
src/execute_stage.sv
src/dual_issue_core.sv
bench/tb_dual_issue_core.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f \
    --top-module tb_dual_issue_core -o tb_dual_issue_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_dual_issue_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
